/* Makefile */
# Verilator flow for the fp16 systolic array testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module systolic_tb \
		-f all.f -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim +verilator+error+limit+1000 > sim.log 2>&1; cat sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* all.f */
+incdir+.
fp16_pkg.sv
fp_mul.sv
fp_add.sv
mac_unit.sv
sa_control.sv
systolic_top.sv
systolic_asserts.sv
systolic_tb.sv

/* fp16_pkg.sv */
// shared half-precision word type and controller state type, referenced by scoped name
`include "mac_defs.svh"

package fp16_pkg;

    // sign, exponent, fraction from msb down
    typedef logic [`FP_W-1:0] fp16_t;

    // controller sequence
    //   idle -> shift x across rows -> start and wait per row -> done
    typedef enum logic [2:0] {
        SA_IDLE,
        SA_SHIFT,
        SA_ROW_START,
        SA_ROW_WAIT,
        SA_DONE
    } sa_state_t;

endpackage

/* fp_add.sv */
// three-stage half-precision adder (align, add, normalize), truncating, used inside mac_unit
`include "mac_defs.svh"

module fp_add (
    input  logic            clk,
    input  logic            nRST,
    input  logic            advance,
    input  fp16_pkg::fp16_t a,
    input  fp16_pkg::fp16_t b,
    output fp16_pkg::fp16_t sum,
    output logic            ovf
);

    // three guard bits below the fraction keep cancellation exact enough
    localparam int ALN_W = `FRAC_W + 4;
    localparam int LZ_W  = $clog2(ALN_W + 1);
    localparam int EXW   = `EXP_W + 2;

    fp16_pkg::fp16_t    big_op, small_op;
    logic [`EXP_W-1:0]  exp_big, exp_small;
    logic [ALN_W-1:0]   sig_big, sig_small;
    logic               inf_in;

    logic               sign_big_q, sign_small_q, inf1_q;
    logic [`EXP_W-1:0]  exp1_q;
    logic [ALN_W-1:0]   sig_big_q, sig_aln_q;

    logic               sign2_q, inf2_q;
    logic [`EXP_W-1:0]  exp2_q;
    logic [ALN_W:0]     sum_q;

    logic [LZ_W-1:0]    lz;
    logic               found;
    logic [ALN_W-1:0]   norm;
    logic signed [EXW-1:0] exp_n;
    logic [`FRAC_W-1:0] frac;
    logic               zero_out;

    // stage 1: order by magnitude, shift the smaller one right
    assign big_op    = (b[`FP_W-2:0] > a[`FP_W-2:0]) ? b : a;
    assign small_op  = (b[`FP_W-2:0] > a[`FP_W-2:0]) ? a : b;
    assign exp_big   = big_op[`FP_W-2 -: `EXP_W];
    assign exp_small = small_op[`FP_W-2 -: `EXP_W];
    assign sig_big   = {(exp_big != '0), big_op[`FRAC_W-1:0], 3'b000};
    assign sig_small = {(exp_small != '0), small_op[`FRAC_W-1:0], 3'b000};
    assign inf_in    = (a[`FP_W-2 -: `EXP_W] == `EXP_MAX) || (b[`FP_W-2 -: `EXP_W] == `EXP_MAX);

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            sign_big_q   <= 1'b0;
            sign_small_q <= 1'b0;
            inf1_q       <= 1'b0;
            exp1_q       <= '0;
            sig_big_q    <= '0;
            sig_aln_q    <= '0;
            sign2_q      <= 1'b0;
            inf2_q       <= 1'b0;
            exp2_q       <= '0;
            sum_q        <= '0;
        end else if (advance) begin
            sign_big_q   <= big_op[`FP_W-1];
            sign_small_q <= small_op[`FP_W-1];
            inf1_q       <= inf_in;
            exp1_q       <= exp_big;
            sig_big_q    <= sig_big;
            sig_aln_q    <= sig_small >> (exp_big - exp_small);
            // stage 2: big magnitude minus small never goes negative
            sign2_q      <= sign_big_q;
            inf2_q       <= inf1_q;
            exp2_q       <= exp1_q;
            sum_q        <= (sign_big_q ^ sign_small_q) ? {1'b0, sig_big_q} - {1'b0, sig_aln_q}
                                                        : {1'b0, sig_big_q} + {1'b0, sig_aln_q};
        end
    end

    // stage 3: leading zero count below the carry bit
    always_comb begin
        lz    = '0;
        found = 1'b0;
        for (int i = ALN_W - 1; i >= 0; i--) begin
            if (!found) begin
                if (sum_q[i]) begin
                    found = 1'b1;
                end else begin
                    lz = lz + 1'b1;
                end
            end
        end
    end

    assign norm  = sum_q[ALN_W-1:0] << lz;
    assign exp_n = sum_q[ALN_W] ? EXW'(exp2_q) + EXW'(1) : EXW'(exp2_q) - EXW'(lz);
    assign frac  = sum_q[ALN_W] ? sum_q[ALN_W-1 -: `FRAC_W] : norm[ALN_W-2 -: `FRAC_W];

    // exact zero and underflow both come out as +0
    assign zero_out = (sum_q == '0) || (exp_n <= 0);
    assign ovf      = inf2_q || (!zero_out && (exp_n >= `EXP_MAX));
    assign sum      = zero_out ? '0 : {sign2_q, exp_n[`EXP_W-1:0], frac};

endmodule

/* fp_mul.sv */
// two-stage half-precision multiplier with truncation and flush to zero, used inside mac_unit
`include "mac_defs.svh"

module fp_mul (
    input  logic            clk,
    input  logic            nRST,
    input  logic            advance,
    input  fp16_pkg::fp16_t a,
    input  fp16_pkg::fp16_t b,
    output fp16_pkg::fp16_t product,
    output logic            ovf
);

    localparam int SIG_W  = `FRAC_W + 1;
    localparam int PROD_W = 2 * SIG_W;
    localparam int EXW    = `EXP_W + 2;

    logic [`EXP_W-1:0]  exp_a, exp_b;
    logic [PROD_W-1:0]  sig_prod;
    logic [`EXP_W-1:0]  exp_a_q, exp_b_q;
    logic [PROD_W-1:0]  prod_q;
    logic               sign_q, zero_q, inf_q;
    logic               carry;
    logic signed [EXW-1:0] exp_sum;
    logic [`FRAC_W-1:0] frac;

    assign exp_a = a[`FP_W-2 -: `EXP_W];
    assign exp_b = b[`FP_W-2 -: `EXP_W];
    // hidden bit is clear for zero exponent, so subnormals vanish here
    assign sig_prod = {(exp_a != '0), a[`FRAC_W-1:0]} * {(exp_b != '0), b[`FRAC_W-1:0]};

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            sign_q  <= 1'b0;
            exp_a_q <= '0;
            exp_b_q <= '0;
            prod_q  <= '0;
            zero_q  <= 1'b0;
            inf_q   <= 1'b0;
        end else if (advance) begin
            sign_q  <= a[`FP_W-1] ^ b[`FP_W-1];
            exp_a_q <= exp_a;
            exp_b_q <= exp_b;
            prod_q  <= sig_prod;
            zero_q  <= (exp_a == '0) || (exp_b == '0);
            inf_q   <= (exp_a == `EXP_MAX) || (exp_b == `EXP_MAX);
        end
    end

    // product in [1,4), top bit set means one extra exponent step
    assign carry   = prod_q[PROD_W-1];
    assign exp_sum = EXW'(exp_a_q) + EXW'(exp_b_q) + EXW'(carry) - EXW'(`EXP_BIAS);
    assign frac    = carry ? prod_q[PROD_W-2 -: `FRAC_W] : prod_q[PROD_W-3 -: `FRAC_W];

    assign ovf     = !zero_q && (inf_q || (exp_sum >= `EXP_MAX));
    assign product = (zero_q || (exp_sum <= 0)) ? '0 : {sign_q, exp_sum[`EXP_W-1:0], frac};

endmodule

/* mac_defs.svh */
// format widths and array size shared by the half-precision MAC array, include where needed
`ifndef MAC_DEFS_SVH
`define MAC_DEFS_SVH

// binary16 layout
`define FP_W 16
`define EXP_W 5
`define FRAC_W 10
`define EXP_BIAS 15
`define EXP_MAX 31

// saturation value for any overflow
`define FP_POS_INF 16'h7C00

// array side, 3 and 4 also work
`define SA_N 2

`endif

/* mac_unit.sv */
// one systolic cell: forwards x along the row and adds weight*x to the partial sum from above
`include "mac_defs.svh"

module mac_unit (
    input  logic            clk,
    input  logic            nRST,
    input  logic            shift,
    input  logic            start,
    input  fp16_pkg::fp16_t in_value,
    input  fp16_pkg::fp16_t weight,
    input  fp16_pkg::fp16_t in_accumulate,
    output fp16_pkg::fp16_t in_pass,
    output fp16_pkg::fp16_t out_accumulate,
    output logic            done
);

    fp16_pkg::fp16_t x_q;
    fp16_pkg::fp16_t product;
    fp16_pkg::fp16_t add_sum;
    logic            run_latched, run;
    logic            start_p1, start_p2, start_p3;
    logic            mul_ovf, mul_ovf_q1, mul_ovf_q2, add_ovf;

    // x latch, also feeds the next cell to the right
    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            x_q <= '0;
        end else if (shift) begin
            x_q <= in_value;
        end
    end

    assign in_pass = x_q;

    // run stays up until the start token leaves the last stage
    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            run_latched <= 1'b0;
        end else begin
            run_latched <= (run_latched | start) & ~start_p3;
        end
    end

    // start enables the first stage in its own cycle
    assign run = run_latched | start;

    // start token and multiplier overflow travel alongside the data
    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            start_p1   <= 1'b0;
            start_p2   <= 1'b0;
            start_p3   <= 1'b0;
            mul_ovf_q1 <= 1'b0;
            mul_ovf_q2 <= 1'b0;
        end else if (run) begin
            start_p1   <= start;
            start_p2   <= start_p1;
            start_p3   <= start_p2;
            mul_ovf_q1 <= mul_ovf;
            mul_ovf_q2 <= mul_ovf_q1;
        end
    end

    fp_mul fp_mul_inst (
        .clk     (clk),
        .nRST    (nRST),
        .advance (run),
        .a       (x_q),
        .b       (weight),
        .product (product),
        .ovf     (mul_ovf)
    );

    fp_add fp_add_inst (
        .clk     (clk),
        .nRST    (nRST),
        .advance (run),
        .a       (product),
        .b       (in_accumulate),
        .sum     (add_sum),
        .ovf     (add_ovf)
    );

    // overflow of either sign saturates to +inf
    assign out_accumulate = (mul_ovf_q2 | add_ovf) ? `FP_POS_INF : add_sum;
    assign done           = start_p3;

endmodule

/* sa_control.sv */
// array controller: shifts x into every row, then starts the rows one after another
`include "mac_defs.svh"

module sa_control (
    input  logic             clk,
    input  logic             nRST,
    input  logic             start,
    input  logic [`SA_N-1:0] row_done,
    output logic             shift,
    output logic [`SA_N-1:0] row_start,
    output logic             busy,
    output logic             valid
);

    localparam int IDX_W = (`SA_N > 1) ? $clog2(`SA_N) : 1;
    localparam logic [IDX_W-1:0] LAST = IDX_W'(`SA_N - 1);

    fp16_pkg::sa_state_t state, next_state;
    logic [IDX_W-1:0]    cnt, next_cnt;
    logic [IDX_W-1:0]    row_idx, next_row;

    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            state   <= fp16_pkg::SA_IDLE;
            cnt     <= '0;
            row_idx <= '0;
        end else begin
            state   <= next_state;
            cnt     <= next_cnt;
            row_idx <= next_row;
        end
    end

    always_comb begin
        next_state = state;
        next_cnt   = cnt;
        next_row   = row_idx;
        case (state)
            fp16_pkg::SA_IDLE: begin
                if (start) begin
                    next_state = fp16_pkg::SA_SHIFT;
                    next_cnt   = '0;
                end
            end
            // one shift per column gets x to the far end of each row
            fp16_pkg::SA_SHIFT: begin
                if (cnt == LAST) begin
                    next_state = fp16_pkg::SA_ROW_START;
                    next_row   = '0;
                end else begin
                    next_cnt = cnt + 1'b1;
                end
            end
            fp16_pkg::SA_ROW_START: next_state = fp16_pkg::SA_ROW_WAIT;
            fp16_pkg::SA_ROW_WAIT: begin
                if (row_done[row_idx]) begin
                    if (row_idx == LAST) begin
                        next_state = fp16_pkg::SA_DONE;
                    end else begin
                        next_row   = row_idx + 1'b1;
                        next_state = fp16_pkg::SA_ROW_START;
                    end
                end
            end
            fp16_pkg::SA_DONE: next_state = fp16_pkg::SA_IDLE;
            default:           next_state = fp16_pkg::SA_IDLE;
        endcase
    end

    always_comb begin
        row_start = '0;
        if (state == fp16_pkg::SA_ROW_START) begin
            row_start[row_idx] = 1'b1;
        end
    end

    assign shift = (state == fp16_pkg::SA_SHIFT);
    assign valid = (state == fp16_pkg::SA_DONE);
    assign busy  = (state != fp16_pkg::SA_IDLE) && (state != fp16_pkg::SA_DONE);

endmodule

/* systolic_asserts.sv */
// protocol checks on the array controller and its outputs, bound into systolic_top
`include "mac_defs.svh"

module systolic_asserts (
    input logic                     clk,
    input logic                     nRST,
    input logic                     start,
    input logic                     busy,
    input logic                     valid,
    input logic                     shift,
    input logic [`SA_N-1:0]         row_start,
    input logic [`SA_N-1:0]         row_done,
    input logic [`SA_N*`FP_W-1:0]   y,
    input fp16_pkg::sa_state_t      state,
    input logic [$clog2(`SA_N)-1:0] row_idx
);

    // number of failed checks so far
    int fail_count = 0;

    a_valid_pulse: assert property (@(posedge clk) disable iff (!nRST) valid |=> !valid)
        else begin
            fail_count++;
            $error("valid stayed high for two cycles");
        end

    a_valid_state: assert property (@(posedge clk) disable iff (!nRST)
        valid |-> (!busy && state == fp16_pkg::SA_DONE))
        else begin
            fail_count++;
            $error("valid without busy low in the done state");
        end

    // y holds its value between runs
    a_y_hold: assert property (@(posedge clk) disable iff (!nRST)
        (!busy && !valid) |-> $stable(y))
        else begin
            fail_count++;
            $error("y changed while idle");
        end

    a_shift_row: assert property (@(posedge clk) disable iff (!nRST) !(shift && |row_start))
        else begin
            fail_count++;
            $error("shift and row_start high together");
        end

    a_start_wait: assert property (@(posedge clk) disable iff (!nRST)
        (start && state == fp16_pkg::SA_ROW_WAIT && !row_done[row_idx])
        |=> (state == fp16_pkg::SA_ROW_WAIT && $stable(row_idx)))
        else begin
            fail_count++;
            $error("start while waiting on a row moved the state or row index");
        end

    // a busy start must not restart the shift phase
    a_start_busy: assert property (@(posedge clk) disable iff (!nRST)
        (start && busy && state != fp16_pkg::SA_SHIFT) |=> state != fp16_pkg::SA_SHIFT)
        else begin
            fail_count++;
            $error("start while busy restarted the x shift");
        end

endmodule

bind systolic_top systolic_asserts systolic_asserts_inst (
    .clk       (clk),
    .nRST      (nRST),
    .start     (start),
    .busy      (busy),
    .valid     (valid),
    .shift     (shift),
    .row_start (row_start),
    .row_done  (row_done),
    .y         (y),
    .state     (sa_control_inst.state),
    .row_idx   (sa_control_inst.row_idx)
);

/* systolic_tb.sv */
// testbench for systolic_top: loads weights, runs x vectors and checks y against exact sums
`include "mac_defs.svh"

module systolic_tb;

    localparam int N       = `SA_N;
    localparam int IW      = $clog2(`SA_N);
    localparam int TIMEOUT = 20 * `SA_N + 40;

    logic               clk;
    logic               nRST;
    logic               weight_we;
    logic [IW-1:0]      weight_row;
    logic [IW-1:0]      weight_col;
    fp16_pkg::fp16_t    weight_data;
    logic [N*`FP_W-1:0] x_in;
    logic               start;
    logic               busy;
    logic               valid;
    logic [N*`FP_W-1:0] y;

    // operands in half units, so 3 stands for 1.5
    int w_half [N][N];
    int x_half [N];
    int seed = 32'hc87f;
    int sat_col = -1;
    int test_num = 0;
    int test_errs = 0;
    int tests_failed = 0;

    systolic_top systolic_top_inst (
        .clk         (clk),
        .nRST        (nRST),
        .weight_we   (weight_we),
        .weight_row  (weight_row),
        .weight_col  (weight_col),
        .weight_data (weight_data),
        .x_in        (x_in),
        .start       (start),
        .busy        (busy),
        .valid       (valid),
        .y           (y)
    );

    always #5 clk = ~clk;

    // signed value n * 2^-scale as binary16, exact up to 11 significant bits
    function automatic fp16_pkg::fp16_t to_fp16(input int n, input int scale);
        int mag;
        int msb;
        int frac;
        fp16_pkg::fp16_t h;
        mag = (n < 0) ? -n : n;
        msb = 0;
        while ((mag >> (msb + 1)) != 0) begin
            msb++;
        end
        frac = (msb <= `FRAC_W) ? (mag << (`FRAC_W - msb)) : (mag >> (msb - `FRAC_W));
        h = {n < 0, `EXP_W'(msb - scale + `EXP_BIAS), `FRAC_W'(frac)};
        if (n == 0) begin
            h = '0;
        end
        return h;
    endfunction

    // exact column sum in quarter units
    function automatic fp16_pkg::fp16_t expected_col(input int c);
        int acc;
        acc = 0;
        for (int r = 0; r < N; r++) begin
            acc += w_half[r][c] * x_half[r];
        end
        return to_fp16(acc, 2);
    endfunction

    // -4.0 to 4.0 in steps of 0.5
    function automatic int random_operand();
        return $random(seed) % 9;
    endfunction

    task automatic load_weights();
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                @(negedge clk);
                weight_we   = 1'b1;
                weight_row  = IW'(r);
                weight_col  = IW'(c);
                weight_data = to_fp16(w_half[r][c], 1);
            end
        end
        @(negedge clk);
        weight_we = 1'b0;
    endtask

    task automatic check_y();
        fp16_pkg::fp16_t got;
        fp16_pkg::fp16_t want;
        for (int c = 0; c < N; c++) begin
            got  = y[c*`FP_W +: `FP_W];
            want = (c == sat_col) ? `FP_POS_INF : expected_col(c);
            if (got !== want) begin
                $display("[FAIL] y[%0d] = %h, expected %h", c, got, want);
                test_errs++;
            end
        end
    endtask

    // poke_busy keeps start high for as long as the array is busy
    task automatic run_vector(input bit poke_busy);
        int cycles;
        int extra;
        @(negedge clk);
        for (int r = 0; r < N; r++) begin
            x_in[r*`FP_W +: `FP_W] = to_fp16(x_half[r], 1);
        end
        start = 1'b1;
        @(negedge clk);
        start  = poke_busy && busy;
        cycles = 0;
        while (!valid && cycles < TIMEOUT) begin
            @(negedge clk);
            start = poke_busy && busy;
            cycles++;
        end
        start = 1'b0;
        if (!valid) begin
            $display("timeout: no valid within %0d cycles in test %0d", TIMEOUT, test_num);
            test_errs++;
        end
        check_y();
        if (poke_busy) begin
            extra = 0;
            for (int i = 0; i < TIMEOUT; i++) begin
                @(negedge clk);
                extra += valid;
            end
            if (extra != 0) begin
                $display("a start while busy produced %0d extra valid pulses", extra);
                test_errs++;
            end
        end
    endtask

    task automatic begin_test();
        test_num++;
        test_errs = 0;
        sat_col   = -1;
    endtask

    task automatic end_test(input string name);
        if (test_errs == 0) begin
            $display("test %0d %s: passed", test_num, name);
        end else begin
            $display("test %0d %s: %0d errors", test_num, name, test_errs);
            tests_failed++;
        end
    endtask

    task automatic random_weights();
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                w_half[r][c] = random_operand();
            end
        end
    endtask

    task automatic random_x();
        for (int r = 0; r < N; r++) begin
            x_half[r] = random_operand();
        end
    endtask

    initial begin
        clk         = 1'b0;
        nRST        = 1'b0;
        weight_we   = 1'b0;
        weight_row  = '0;
        weight_col  = '0;
        weight_data = '0;
        x_in        = '0;
        start       = 1'b0;
        repeat (8) @(negedge clk);
        nRST = 1'b1;

        // all operand arrays are still zero, so y must be zero
        begin_test();
        @(negedge clk);
        if (busy !== 1'b0) begin
            $display("[FAIL] busy = %h, expected 0", busy);
            test_errs++;
        end
        if (valid !== 1'b0) begin
            $display("[FAIL] valid = %h, expected 0", valid);
            test_errs++;
        end
        check_y();
        end_test("reset state");

        begin_test();
        random_weights();
        random_x();
        load_weights();
        run_vector(1'b0);
        end_test("random weights and x");

        // +1.5 and -1.5 rows against x = 2.0 cancel in every column
        begin_test();
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                w_half[r][c] = (r == N - 1 && N % 2 == 1) ? 0 : ((r % 2 == 0) ? 3 : -3);
            end
            x_half[r] = 4;
        end
        load_weights();
        run_vector(1'b0);
        end_test("cancellation to +0");

        // -256 * 256 overflows column 0, other columns stay exact
        begin_test();
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                w_half[r][c] = 2 * ((r + c) % 3 + 1);
            end
            x_half[r] = 2 * (r + 1);
        end
        w_half[0][0] = -512;
        x_half[0]    = 512;
        sat_col      = 0;
        load_weights();
        run_vector(1'b0);
        end_test("overflow saturation");

        begin_test();
        random_weights();
        random_x();
        load_weights();
        run_vector(1'b1);
        random_x();
        run_vector(1'b0);
        end_test("held weights and start while busy");

        begin_test();
        random_weights();
        load_weights();
        for (int i = 0; i < 20; i++) begin
            random_x();
            run_vector(1'b0);
        end
        end_test("20 random vectors");

        $display("%0d tests run, %0d passed, %0d failed, %0d assertion failures",
                 test_num, test_num - tests_failed, tests_failed,
                 systolic_top_inst.systolic_asserts_inst.fail_count);
        if (tests_failed == 0 && systolic_top_inst.systolic_asserts_inst.fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* systolic_top.sv */
// top of the weight-stationary fp16 array, y = W^T x from the bottom row of cells
`include "mac_defs.svh"

module systolic_top (
    input  logic                     clk,
    input  logic                     nRST,
    input  logic                     weight_we,
    input  logic [$clog2(`SA_N)-1:0] weight_row,
    input  logic [$clog2(`SA_N)-1:0] weight_col,
    input  fp16_pkg::fp16_t          weight_data,
    input  logic [`SA_N*`FP_W-1:0]   x_in,
    input  logic                     start,
    output logic                     busy,
    output logic                     valid,
    output logic [`SA_N*`FP_W-1:0]   y
);

    fp16_pkg::fp16_t  weight_q [`SA_N][`SA_N];
    fp16_pkg::fp16_t  val_in   [`SA_N][`SA_N];
    fp16_pkg::fp16_t  acc_in   [`SA_N][`SA_N];
    fp16_pkg::fp16_t  pass_w   [`SA_N][`SA_N];
    fp16_pkg::fp16_t  acc_w    [`SA_N][`SA_N];
    logic             done_w   [`SA_N][`SA_N];
    logic [`SA_N-1:0] row_done;
    logic [`SA_N-1:0] row_start;
    logic             shift;

    // weights only change while the controller is idle
    always_ff @(posedge clk, negedge nRST) begin
        if (!nRST) begin
            for (int r = 0; r < `SA_N; r++) begin
                for (int c = 0; c < `SA_N; c++) begin
                    weight_q[r][c] <= '0;
                end
            end
        end else if (weight_we && !busy && !valid) begin
            weight_q[weight_row][weight_col] <= weight_data;
        end
    end

    sa_control sa_control_inst (
        .clk       (clk),
        .nRST      (nRST),
        .start     (start),
        .row_done  (row_done),
        .shift     (shift),
        .row_start (row_start),
        .busy      (busy),
        .valid     (valid)
    );

    for (genvar r = 0; r < `SA_N; r++) begin : g_row
        for (genvar c = 0; c < `SA_N; c++) begin : g_col
            if (c == 0) begin : g_left
                assign val_in[r][c] = x_in[r*`FP_W +: `FP_W];
            end else begin : g_inner
                assign val_in[r][c] = pass_w[r][c-1];
            end
            // top row starts from +0
            if (r == 0) begin : g_top
                assign acc_in[r][c] = '0;
            end else begin : g_below
                assign acc_in[r][c] = acc_w[r-1][c];
            end

            mac_unit mac_unit_inst (
                .clk            (clk),
                .nRST           (nRST),
                .shift          (shift),
                .start          (row_start[r]),
                .in_value       (val_in[r][c]),
                .weight         (weight_q[r][c]),
                .in_accumulate  (acc_in[r][c]),
                .in_pass        (pass_w[r][c]),
                .out_accumulate (acc_w[r][c]),
                .done           (done_w[r][c])
            );
        end
        // the whole row starts together, column 0 speaks for it
        assign row_done[r] = done_w[r][0];
    end

    for (genvar c = 0; c < `SA_N; c++) begin : g_out
        assign y[c*`FP_W +: `FP_W] = acc_w[`SA_N-1][c];
    end

endmodule
